/* include/fifo_params.svh */
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// write side word width
`define FIFO_IN_WIDTH      32

// read side item width
`define FIFO_OUT_WIDTH     8

// items per word, and bits to pick one
`define FIFO_RATIO         4
`define FIFO_LANE_BITS     2

// capacity in words
`define FIFO_WR_DEPTH      16
`define FIFO_WR_ADDR_BITS  4

// same capacity counted in items
`define FIFO_RD_DEPTH      64
`define FIFO_RD_ADDR_BITS  6

`endif

/* logic/fifo_data_pkg.sv */
`include "fifo_params.svh"

package fifo_data_pkg;

    // one word as written
    typedef logic [`FIFO_IN_WIDTH-1:0] in_word_t;

    // one item as read
    typedef logic [`FIFO_OUT_WIDTH-1:0] out_item_t;

    // lane 0 is the most significant byte of a word
    typedef logic [`FIFO_LANE_BITS-1:0] lane_t;

endpackage

/* logic/fifo_ptr_pkg.sv */
`include "fifo_params.svh"

package fifo_ptr_pkg;

    // pointers are {wrap, gray(address)}
    // the wrap bit stays plain binary, so full is a wrap-only difference
    typedef logic [`FIFO_WR_ADDR_BITS:0] wr_ptr_t;
    typedef logic [`FIFO_RD_ADDR_BITS:0] rd_ptr_t;

    typedef logic [`FIFO_WR_ADDR_BITS-1:0] word_addr_t;

    // counts need one bit more than the address to reach the depth
    typedef logic [`FIFO_WR_ADDR_BITS:0] wr_count_t;
    typedef logic [`FIFO_RD_ADDR_BITS:0] rd_count_t;

    function automatic wr_ptr_t wr_to_bin(input wr_ptr_t g);
        wr_ptr_t b;
        b[`FIFO_WR_ADDR_BITS] = g[`FIFO_WR_ADDR_BITS];
        b[`FIFO_WR_ADDR_BITS-1] = g[`FIFO_WR_ADDR_BITS-1];
        for (int i = `FIFO_WR_ADDR_BITS - 2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    function automatic wr_ptr_t wr_to_gray(input wr_ptr_t b);
        return {b[`FIFO_WR_ADDR_BITS],
                b[`FIFO_WR_ADDR_BITS-1:0] ^ (b[`FIFO_WR_ADDR_BITS-1:0] >> 1)};
    endfunction

    function automatic rd_ptr_t rd_to_bin(input rd_ptr_t g);
        rd_ptr_t b;
        b[`FIFO_RD_ADDR_BITS] = g[`FIFO_RD_ADDR_BITS];
        b[`FIFO_RD_ADDR_BITS-1] = g[`FIFO_RD_ADDR_BITS-1];
        for (int i = `FIFO_RD_ADDR_BITS - 2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    function automatic rd_ptr_t rd_to_gray(input rd_ptr_t b);
        return {b[`FIFO_RD_ADDR_BITS],
                b[`FIFO_RD_ADDR_BITS-1:0] ^ (b[`FIFO_RD_ADDR_BITS-1:0] >> 1)};
    endfunction

endpackage

/* logic/fifo_ram.sv */
`timescale 1ns/100ps

`include "fifo_params.svh"

module fifo_ram (
    input  logic                     clock,
    input  logic                     we,
    input  fifo_ptr_pkg::word_addr_t waddr,
    input  fifo_data_pkg::in_word_t  wdata,
    input  logic                     re,
    input  fifo_ptr_pkg::word_addr_t raddr,
    input  fifo_data_pkg::lane_t     lane,
    output fifo_data_pkg::out_item_t rdata
);

    localparam int LAST_LANE = `FIFO_RATIO - 1;

    fifo_data_pkg::in_word_t mem [`FIFO_WR_DEPTH];
    fifo_data_pkg::in_word_t rd_word;

    // whole words go in
    always_ff @(posedge clock) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rd_word = mem[raddr];

    // one byte comes out, lane 0 from the top of the word
    // rdata keeps its value between reads
    always_ff @(posedge clock) begin
        if (re) begin
            rdata <= rd_word[(LAST_LANE - lane) * `FIFO_OUT_WIDTH +: `FIFO_OUT_WIDTH];
        end
    end

endmodule

/* logic/fifo_rd_ctrl.sv */
`timescale 1ns/100ps

`include "fifo_params.svh"

module fifo_rd_ctrl (
    input  logic                     clock,
    input  logic                     sys_rst,
    input  logic                     rd_en,
    input  logic                     empty,
    output fifo_ptr_pkg::rd_ptr_t    rd_ptr,
    output logic                     ram_re,
    output fifo_ptr_pkg::word_addr_t ram_raddr,
    output fifo_data_pkg::lane_t     ram_lane,
    output logic                     valid
);

    logic                  rd_accept;
    fifo_ptr_pkg::rd_ptr_t rd_bin;

    // reads on an empty fifo are ignored
    assign rd_accept = rd_en & ~empty;

    assign rd_bin = fifo_ptr_pkg::rd_to_bin(rd_ptr);

    // item pointer, one step per accepted read
    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            rd_ptr <= '0;
        end else if (rd_accept) begin
            rd_ptr <= fifo_ptr_pkg::rd_to_gray(rd_bin + 1'b1);
        end
    end

    // upper binary bits select the word, low bits the lane
    // lane 0 is turned into the top byte inside the memory
    assign ram_raddr = rd_bin[`FIFO_RD_ADDR_BITS-1:`FIFO_LANE_BITS];
    assign ram_lane  = rd_bin[`FIFO_LANE_BITS-1:0];
    assign ram_re    = rd_accept;

    // matches the one-cycle memory read latency
    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            valid <= 1'b0;
        end else begin
            valid <= rd_accept;
        end
    end

endmodule

/* logic/fifo_status.sv */
`timescale 1ns/100ps

`include "fifo_params.svh"

module fifo_status (
    input  fifo_ptr_pkg::wr_ptr_t   wr_ptr,
    input  fifo_ptr_pkg::rd_ptr_t   rd_ptr,
    output logic                    full,
    output logic                    empty,
    output logic                    wr_ready,
    output fifo_ptr_pkg::wr_count_t wr_data_count,
    output fifo_ptr_pkg::wr_count_t wr_data_space,
    output fifo_ptr_pkg::rd_count_t rd_data_count,
    output fifo_ptr_pkg::rd_count_t rd_data_space
);

    localparam int WRAP = `FIFO_WR_ADDR_BITS;

    fifo_ptr_pkg::wr_ptr_t rd_word_ptr;
    fifo_ptr_pkg::wr_ptr_t wr_bin;
    fifo_ptr_pkg::rd_ptr_t rd_bin;
    fifo_ptr_pkg::wr_ptr_t rd_word_bin;

    // dropping the lane bits of a gray code leaves the gray word index
    assign rd_word_ptr = rd_ptr[`FIFO_RD_ADDR_BITS:`FIFO_LANE_BITS];

    // flags straight from the gray pointers
    assign empty = (rd_word_ptr == wr_ptr);

    assign full = (wr_ptr[WRAP] != rd_word_ptr[WRAP]) &&
                  (wr_ptr[WRAP-1:0] == rd_word_ptr[WRAP-1:0]);

    assign wr_ready = ~full;

    // binary forms for the counters
    assign wr_bin      = fifo_ptr_pkg::wr_to_bin(wr_ptr);
    assign rd_bin      = fifo_ptr_pkg::rd_to_bin(rd_ptr);
    assign rd_word_bin = rd_bin[`FIFO_RD_ADDR_BITS:`FIFO_LANE_BITS];

    // a word only frees its slot once all four lanes are gone
    assign wr_data_count = wr_bin - rd_word_bin;

    // written words scaled to items, minus items read
    assign rd_data_count = {wr_bin, {`FIFO_LANE_BITS{1'b0}}} - rd_bin;

    assign wr_data_space = fifo_ptr_pkg::wr_count_t'(`FIFO_WR_DEPTH) - wr_data_count;
    assign rd_data_space = fifo_ptr_pkg::rd_count_t'(`FIFO_RD_DEPTH) - rd_data_count;

endmodule

/* logic/fifo_wr_ctrl.sv */
`timescale 1ns/100ps

`include "fifo_params.svh"

module fifo_wr_ctrl (
    input  logic                     clock,
    input  logic                     sys_rst,
    input  logic                     wr_en,
    input  logic                     full,
    input  fifo_data_pkg::in_word_t  din,
    output fifo_ptr_pkg::wr_ptr_t    wr_ptr,
    output logic                     ram_we,
    output fifo_ptr_pkg::word_addr_t ram_waddr,
    output fifo_data_pkg::in_word_t  ram_wdata
);

    logic                  wr_accept;
    fifo_ptr_pkg::wr_ptr_t wr_bin;

    // a write while full is simply dropped
    assign wr_accept = wr_en & ~full;

    assign wr_bin = fifo_ptr_pkg::wr_to_bin(wr_ptr);

    // step through binary, store back as gray
    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            wr_ptr <= '0;
        end else if (wr_accept) begin
            wr_ptr <= fifo_ptr_pkg::wr_to_gray(wr_bin + 1'b1);
        end
    end

    // memory side, wrap bit dropped from the address
    assign ram_we    = wr_accept;
    assign ram_waddr = wr_bin[`FIFO_WR_ADDR_BITS-1:0];
    assign ram_wdata = din;

endmodule

/* logic/width_conv_fifo.sv */
`timescale 1ns/100ps

module width_conv_fifo (
    input  logic                     clock,
    input  logic                     sys_rst,

    // write side
    input  logic                     wr_en,
    input  fifo_data_pkg::in_word_t  din,
    output logic                     wr_ready,

    // read side
    input  logic                     rd_en,
    output logic                     valid,
    output fifo_data_pkg::out_item_t dout,

    // status
    output logic                     full,
    output logic                     empty,
    output fifo_ptr_pkg::wr_count_t  wr_data_count,
    output fifo_ptr_pkg::wr_count_t  wr_data_space,
    output fifo_ptr_pkg::rd_count_t  rd_data_count,
    output fifo_ptr_pkg::rd_count_t  rd_data_space
);

    fifo_ptr_pkg::wr_ptr_t    wr_ptr;
    fifo_ptr_pkg::rd_ptr_t    rd_ptr;

    // memory write port
    logic                     ram_we;
    fifo_ptr_pkg::word_addr_t ram_waddr;
    fifo_data_pkg::in_word_t  ram_wdata;

    // memory read port
    logic                     ram_re;
    fifo_ptr_pkg::word_addr_t ram_raddr;
    fifo_data_pkg::lane_t     ram_lane;

    fifo_wr_ctrl i_wr_ctrl (
        .clock     (clock),
        .sys_rst   (sys_rst),
        .wr_en     (wr_en),
        .full      (full),
        .din       (din),
        .wr_ptr    (wr_ptr),
        .ram_we    (ram_we),
        .ram_waddr (ram_waddr),
        .ram_wdata (ram_wdata)
    );

    fifo_rd_ctrl i_rd_ctrl (
        .clock     (clock),
        .sys_rst   (sys_rst),
        .rd_en     (rd_en),
        .empty     (empty),
        .rd_ptr    (rd_ptr),
        .ram_re    (ram_re),
        .ram_raddr (ram_raddr),
        .ram_lane  (ram_lane),
        .valid     (valid)
    );

    // registered byte output doubles as dout
    fifo_ram i_ram (
        .clock (clock),
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .re    (ram_re),
        .raddr (ram_raddr),
        .lane  (ram_lane),
        .rdata (dout)
    );

    // flags and counts from both pointers
    fifo_status i_status (
        .wr_ptr        (wr_ptr),
        .rd_ptr        (rd_ptr),
        .full          (full),
        .empty         (empty),
        .wr_ready      (wr_ready),
        .wr_data_count (wr_data_count),
        .wr_data_space (wr_data_space),
        .rd_data_count (rd_data_count),
        .rd_data_space (rd_data_space)
    );

endmodule

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then look for the fail message in the log

cd "$(dirname "$0")" &&
rm -rf obj_dir build.log sim.log &&
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_width_conv_fifo \
    -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "Regression failed" sim.log &&
{ echo "result: FAIL"; exit 1; } ||
{ echo "result: PASS"; exit 0; }

/* src.f */
+incdir+include
logic/fifo_data_pkg.sv
logic/fifo_ptr_pkg.sv
logic/fifo_wr_ctrl.sv
logic/fifo_rd_ctrl.sv
logic/fifo_status.sv
logic/fifo_ram.sv
logic/width_conv_fifo.sv
tests/tb_clock_gen.sv
tests/tb_width_conv_fifo.sv

/* tests/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clock,
    output logic sys_rst
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // release lands on a falling edge
    initial begin
        sys_rst = 1'b0;
        #(PERIOD * RESET_CYCLES);
        sys_rst = 1'b1;
    end

endmodule

/* tests/tb_width_conv_fifo.sv */
`timescale 1ns/100ps

`include "fifo_params.svh"

module tb_width_conv_fifo;

    localparam int CLOCK_PERIOD    = 8;
    localparam int RESET_CYCLES    = 10;
    localparam int WATCHDOG_MARGIN = 100;

    // step operations
    localparam int OP_IDLE       = 0;
    localparam int OP_WR         = 1;
    localparam int OP_RD         = 2;
    localparam int OP_BOTH       = 3;
    localparam int OP_RAND_FILL  = 4;
    localparam int OP_RAND_DRAIN = 5;

    localparam int NUM_STEPS = 17;

    // stimulus table, one column per array, word i of a step is data + i
    localparam int STEP_OP [NUM_STEPS] = '{
        OP_IDLE, OP_WR, OP_RD, OP_RD, OP_WR, OP_WR, OP_IDLE, OP_RD, OP_WR,
        OP_WR, OP_BOTH, OP_RD, OP_BOTH, OP_RAND_FILL, OP_RAND_DRAIN, OP_RD, OP_IDLE
    };

    localparam logic [31:0] STEP_DATA [NUM_STEPS] = '{
        32'h0000_0000, 32'h1122_3344, 32'h0000_0000, 32'h0000_0000,
        32'hA0B1_C2D0, 32'hDEAD_BEEF, 32'h0000_0000, 32'h0000_0000,
        32'h5566_7788, 32'hBAD0_0BAD, 32'h0102_0300, 32'h0000_0000,
        32'h7700_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000,
        32'h0000_0000
    };

    // 12 reads drain the first 3 words, 2 more hit an empty fifo,
    // 16 writes fill it and the next 2 are dropped
    localparam int STEP_REPS [NUM_STEPS] = '{
        2, 3, 12, 2, 16, 2, 1, 5, 1, 1, 20, 70, 10, 150, 150, 80, 2
    };

    logic                     clock;
    logic                     sys_rst;
    logic                     wr_en;
    fifo_data_pkg::in_word_t  din;
    logic                     wr_ready;
    logic                     rd_en;
    logic                     valid;
    fifo_data_pkg::out_item_t dout;
    logic                     full;
    logic                     empty;
    fifo_ptr_pkg::wr_count_t  wr_data_count;
    fifo_ptr_pkg::wr_count_t  wr_data_space;
    fifo_ptr_pkg::rd_count_t  rd_data_count;
    fifo_ptr_pkg::rd_count_t  rd_data_space;

    // reference model, bytes in read order
    fifo_data_pkg::out_item_t model_q [$];
    int                       words_in;
    int                       items_out;
    fifo_data_pkg::out_item_t exp_dout;
    logic                     exp_valid;
    logic                     dout_known;

    int     error_count;
    int     check_count;
    integer seed;

    tb_clock_gen #(
        .PERIOD       (CLOCK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) i_clock_gen (
        .clock   (clock),
        .sys_rst (sys_rst)
    );

    width_conv_fifo i_width_conv_fifo (
        .clock         (clock),
        .sys_rst       (sys_rst),
        .wr_en         (wr_en),
        .din           (din),
        .wr_ready      (wr_ready),
        .rd_en         (rd_en),
        .valid         (valid),
        .dout          (dout),
        .full          (full),
        .empty         (empty),
        .wr_data_count (wr_data_count),
        .wr_data_space (wr_data_space),
        .rd_data_count (rd_data_count),
        .rd_data_space (rd_data_space)
    );

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t ns %s actual=%0h expected=%0h", $time, name, actual, expected);
        end
    endtask

    // expected status from the model totals
    task automatic check_outputs();
        int exp_wr_count;
        int exp_rd_count;
        exp_wr_count = words_in - items_out / `FIFO_RATIO;
        exp_rd_count = words_in * `FIFO_RATIO - items_out;
        check_equal("valid", valid, exp_valid);
        if (dout_known) begin
            check_equal("dout", dout, exp_dout);
        end
        check_equal("empty", empty, exp_rd_count == 0);
        check_equal("full", full, exp_wr_count == `FIFO_WR_DEPTH);
        check_equal("wr_ready", wr_ready, exp_wr_count != `FIFO_WR_DEPTH);
        check_equal("wr_data_count", wr_data_count, exp_wr_count);
        check_equal("wr_data_space", wr_data_space, `FIFO_WR_DEPTH - exp_wr_count);
        check_equal("rd_data_count", rd_data_count, exp_rd_count);
        check_equal("rd_data_space", rd_data_space, `FIFO_RD_DEPTH - exp_rd_count);
    endtask

    // one clock of traffic, entered 1 ns after a rising edge
    task automatic run_cycle(input logic do_wr, input logic do_rd,
                             input fifo_data_pkg::in_word_t word);
        logic                    wr_ok;
        logic                    rd_ok;
        int                      word_fill;
        fifo_data_pkg::in_word_t shifted;
        word_fill = words_in - items_out / `FIFO_RATIO;
        wr_ok = do_wr && (word_fill < `FIFO_WR_DEPTH);
        rd_ok = do_rd && (model_q.size() > 0);
        wr_en = do_wr;
        rd_en = do_rd;
        din   = word;
        @(posedge clock);
        #1;
        if (rd_ok) begin
            exp_dout = model_q.pop_front();
            dout_known = 1'b1;
            items_out++;
        end
        if (wr_ok) begin
            shifted = word;
            // top byte leaves first
            for (int lane = 0; lane < `FIFO_RATIO; lane++) begin
                model_q.push_back(shifted[31:24]);
                shifted = shifted << 8;
            end
            words_in++;
        end
        exp_valid = rd_ok;
        check_outputs();
    endtask

    initial begin : stimulus
        logic [31:0]             r;
        logic                    do_wr;
        logic                    do_rd;
        fifo_data_pkg::in_word_t word;

        wr_en       = 1'b0;
        rd_en       = 1'b0;
        din         = '0;
        words_in    = 0;
        items_out   = 0;
        exp_dout    = '0;
        exp_valid   = 1'b0;
        dout_known  = 1'b0;
        error_count = 0;
        check_count = 0;
        seed        = 32'hc213_1dcf;

        wait (sys_rst === 1'b1);
        @(posedge clock);
        #1;
        // state right after reset
        check_outputs();

        for (int s = 0; s < NUM_STEPS; s++) begin
            for (int i = 0; i < STEP_REPS[s]; i++) begin
                word  = STEP_DATA[s] + 32'(i);
                do_wr = 1'b0;
                do_rd = 1'b0;
                case (STEP_OP[s])
                    OP_WR: begin
                        do_wr = 1'b1;
                    end
                    OP_RD: begin
                        do_rd = 1'b1;
                    end
                    OP_BOTH: begin
                        do_wr = 1'b1;
                        do_rd = 1'b1;
                    end
                    OP_RAND_FILL: begin
                        // writes outrun reads, runs into full
                        r     = $random(seed);
                        do_wr = r[0];
                        do_rd = (r[2:1] != 2'b00);
                        word  = $random(seed);
                    end
                    OP_RAND_DRAIN: begin
                        // reads outrun writes, runs into empty
                        r     = $random(seed);
                        do_wr = (r[3:0] == 4'b0000);
                        do_rd = (r[5:4] != 2'b00);
                        word  = $random(seed);
                    end
                    default: begin
                        do_wr = 1'b0;
                    end
                endcase
                run_cycle(do_wr, do_rd, word);
            end
        end

        wr_en = 1'b0;
        rd_en = 1'b0;

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // limit from the table length plus reset and a margin
    initial begin : watchdog
        int total;
        total = RESET_CYCLES + WATCHDOG_MARGIN;
        for (int s = 0; s < NUM_STEPS; s++) begin
            total += STEP_REPS[s];
        end
        #(total * CLOCK_PERIOD);
        $display("Watchdog expired after %0d cycles, the test did not reach its end", total);
        $display("Regression failed");
        $finish;
    end

endmodule
